/* verilog/muldiv_pkg.sv */
package muldiv_pkg;

    // datapath widths
    localparam int xlen        = 32;
    localparam int prod_width  = 64;     // sign-extended operands and full product

    // multiplier pipeline depth, must divide prod_width (2, 4 or 8)
    localparam int mult_stages = 4;
    localparam int slice_width = prod_width / mult_stages;  // multiplier bits per stage

    // operation tag carried from issue to completion
    localparam int tag_width   = 4;

    // divider step counter, counts xlen steps down to zero
    localparam int div_count_width = $clog2(xlen);

    // RV32M operations, in funct3 order
    // bit 2 clear is a multiply, bit 2 set is a divide or remainder
    typedef enum logic [2:0] {
        op_mul    = 3'd0,    // low word, signed x signed
        op_mulh   = 3'd1,    // high word, signed x signed
        op_mulhsu = 3'd2,    // high word, signed x unsigned
        op_mulhu  = 3'd3,    // high word, unsigned x unsigned
        op_div    = 3'd4,
        op_divu   = 3'd5,
        op_rem    = 3'd6,
        op_remu   = 3'd7
    } muldiv_func_e;

    // iterative divider states
    typedef enum logic [1:0] {
        div_idle = 2'd0,     // ready for a new divide
        div_busy = 2'd1,     // shift-subtract steps running
        div_hold = 2'd2      // result waiting for the arbiter
    } div_state_e;

endpackage

/* verilog/mult_stage.sv */
module mult_stage (
    input  logic                              clock,
    input  logic                              reset,
    input  logic                              start,
    input  logic [muldiv_pkg::prod_width-1:0] prev_sum,
    input  logic [muldiv_pkg::prod_width-1:0] mplier,
    input  logic [muldiv_pkg::prod_width-1:0] mcand,
    input  muldiv_pkg::muldiv_func_e          func,
    input  logic [muldiv_pkg::tag_width-1:0]  tag_in,
    output logic [muldiv_pkg::prod_width-1:0] product_sum,
    output logic [muldiv_pkg::prod_width-1:0] next_mplier,
    output logic [muldiv_pkg::prod_width-1:0] next_mcand,
    output muldiv_pkg::muldiv_func_e          next_func,
    output logic [muldiv_pkg::tag_width-1:0]  tag_out,
    output logic                              done
);
    import muldiv_pkg::*;

    logic [prod_width-1:0] partial_product;
    logic [prod_width-1:0] shifted_mplier;
    logic [prod_width-1:0] shifted_mcand;

    // one slice of the multiplier against the whole multiplicand
    assign partial_product = mplier[slice_width-1:0] * mcand;

    assign shifted_mplier = {{slice_width{1'b0}}, mplier[prod_width-1:slice_width]};
    assign shifted_mcand  = {mcand[prod_width-slice_width-1:0], {slice_width{1'b0}}};

    always_ff @(posedge clock) begin
        product_sum <= prev_sum + partial_product;
        next_mplier <= shifted_mplier;
        next_mcand  <= shifted_mcand;
        next_func   <= func;
        tag_out     <= tag_in;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= start;    // valid bit walks down the chain
        end
    end

endmodule

/* verilog/mult_pipe.sv */
module mult_pipe (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             issue_valid,
    input  muldiv_pkg::muldiv_func_e         issue_func,
    input  logic [muldiv_pkg::xlen-1:0]      issue_rs1,
    input  logic [muldiv_pkg::xlen-1:0]      issue_rs2,
    input  logic [muldiv_pkg::tag_width-1:0] issue_tag,
    output logic                             mult_done,
    output logic [muldiv_pkg::tag_width-1:0] mult_tag,
    output logic [muldiv_pkg::xlen-1:0]      mult_result
);
    import muldiv_pkg::*;

    logic                  mult_start;
    logic [prod_width-1:0] ext_rs1;
    logic [prod_width-1:0] ext_rs2;

    // element 0 feeds the first stage, element mult_stages leaves the last
    logic [mult_stages:0]                 done_chain;
    logic [mult_stages:0][prod_width-1:0] sum_chain;
    logic [mult_stages:0][prod_width-1:0] mplier_chain;
    logic [mult_stages:0][prod_width-1:0] mcand_chain;
    muldiv_func_e [mult_stages:0]         func_chain;
    logic [mult_stages:0][tag_width-1:0]  tag_chain;

    assign mult_start = issue_valid &&
                        (issue_func inside {op_mul, op_mulh, op_mulhsu, op_mulhu});

    // extend to 64 bits so the low 64 product bits are exact for every mode
    always_comb begin
        case (issue_func)
            op_mul, op_mulh, op_mulhsu: ext_rs1 = {{(prod_width-xlen){issue_rs1[xlen-1]}}, issue_rs1};
            default:                    ext_rs1 = {{(prod_width-xlen){1'b0}}, issue_rs1};
        endcase
        case (issue_func)
            op_mul, op_mulh: ext_rs2 = {{(prod_width-xlen){issue_rs2[xlen-1]}}, issue_rs2};
            default:         ext_rs2 = {{(prod_width-xlen){1'b0}}, issue_rs2};
        endcase
    end

    assign done_chain[0]   = mult_start;
    assign sum_chain[0]    = '0;          // running sum starts empty
    assign mplier_chain[0] = ext_rs2;
    assign mcand_chain[0]  = ext_rs1;
    assign func_chain[0]   = issue_func;
    assign tag_chain[0]    = issue_tag;

    // each instance takes element i and produces element i+1
    mult_stage stage_inst [mult_stages-1:0] (
        .clock       (clock),
        .reset       (reset),
        .start       (done_chain[mult_stages-1:0]),
        .prev_sum    (sum_chain[mult_stages-1:0]),
        .mplier      (mplier_chain[mult_stages-1:0]),
        .mcand       (mcand_chain[mult_stages-1:0]),
        .func        (func_chain[mult_stages-1:0]),
        .tag_in      (tag_chain[mult_stages-1:0]),
        .product_sum (sum_chain[mult_stages:1]),
        .next_mplier (mplier_chain[mult_stages:1]),  // last shifted operands are dropped
        .next_mcand  (mcand_chain[mult_stages:1]),
        .next_func   (func_chain[mult_stages:1]),
        .tag_out     (tag_chain[mult_stages:1]),
        .done        (done_chain[mult_stages:1])
    );

    assign mult_done = done_chain[mult_stages];
    assign mult_tag  = tag_chain[mult_stages];

    // word select uses the function that travelled with the operands
    assign mult_result = (func_chain[mult_stages] == op_mul) ?
                         sum_chain[mult_stages][xlen-1:0] :
                         sum_chain[mult_stages][prod_width-1:xlen];

endmodule

/* verilog/div_iter.sv */
module div_iter (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             issue_valid,
    input  muldiv_pkg::muldiv_func_e         issue_func,
    input  logic [muldiv_pkg::xlen-1:0]      issue_rs1,
    input  logic [muldiv_pkg::xlen-1:0]      issue_rs2,
    input  logic [muldiv_pkg::tag_width-1:0] issue_tag,
    input  logic                             div_grant,
    output logic                             div_ready,
    output logic                             div_done,
    output logic [muldiv_pkg::tag_width-1:0] div_tag,
    output logic [muldiv_pkg::xlen-1:0]      div_result
);
    import muldiv_pkg::*;

    div_state_e state;

    // issue side decode
    logic            start;
    logic            is_signed;
    logic            is_rem;
    logic            div_by_zero;
    logic            overflow;
    logic [xlen-1:0] abs_rs1;
    logic [xlen-1:0] abs_rs2;

    // iteration registers
    logic [xlen-1:0]            quo;        // dividend shifts out, quotient shifts in
    logic [xlen-1:0]            rem;
    logic [xlen-1:0]            divisor;
    logic [div_count_width-1:0] count;
    logic                       neg_quot;
    logic                       neg_rem;
    logic                       want_rem;
    logic [tag_width-1:0]       tag_q;
    logic [xlen-1:0]            result_q;

    // one restoring step
    logic [xlen:0]   shifted;
    logic [xlen:0]   diff;
    logic [xlen-1:0] quo_next;
    logic [xlen-1:0] rem_next;
    logic [xlen-1:0] quo_fix;
    logic [xlen-1:0] rem_fix;

    assign start = issue_valid && (state == div_idle) &&
                   (issue_func inside {op_div, op_divu, op_rem, op_remu});

    assign is_signed   = issue_func inside {op_div, op_rem};
    assign is_rem      = issue_func inside {op_rem, op_remu};
    assign div_by_zero = (issue_rs2 == '0);
    assign overflow    = is_signed && (issue_rs1 == {1'b1, {(xlen-1){1'b0}}}) &&
                         (issue_rs2 == '1);   // most negative / -1

    assign abs_rs1 = (is_signed && issue_rs1[xlen-1]) ? -issue_rs1 : issue_rs1;
    assign abs_rs2 = (is_signed && issue_rs2[xlen-1]) ? -issue_rs2 : issue_rs2;

    assign shifted  = {rem, quo[xlen-1]};
    assign diff     = shifted - {1'b0, divisor};
    assign quo_next = {quo[xlen-2:0], ~diff[xlen]};                  // borrow means bit 0
    assign rem_next = diff[xlen] ? shifted[xlen-1:0] : diff[xlen-1:0];  // restore on borrow

    // remainder takes the dividend sign, quotient the xor of both
    assign quo_fix = neg_quot ? -quo_next : quo_next;
    assign rem_fix = neg_rem ? -rem_next : rem_next;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= div_idle;
        end else begin
            case (state)
                div_idle: if (start) state <= (div_by_zero || overflow) ? div_hold : div_busy;
                div_busy: if (count == '0) state <= div_hold;
                div_hold: if (div_grant) state <= div_idle;
                default:  state <= div_idle;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            quo      <= abs_rs1;
            rem      <= '0;
            divisor  <= abs_rs2;
            count    <= div_count_width'(xlen - 1);
            neg_quot <= is_signed && (issue_rs1[xlen-1] ^ issue_rs2[xlen-1]);
            neg_rem  <= is_signed && issue_rs1[xlen-1];
            want_rem <= is_rem;
            tag_q    <= issue_tag;
            // corner cases are resolved right here and skip the steps
            if (div_by_zero) begin
                result_q <= is_rem ? issue_rs1 : '1;
            end else if (overflow) begin
                result_q <= is_rem ? '0 : issue_rs1;
            end
        end else if (state == div_busy) begin
            quo   <= quo_next;
            rem   <= rem_next;
            count <= count - 1'b1;
            if (count == '0) begin
                result_q <= want_rem ? rem_fix : quo_fix;   // last step
            end
        end
    end

    assign div_ready  = (state == div_idle);
    assign div_done   = (state == div_hold);
    assign div_tag    = tag_q;
    assign div_result = result_q;

endmodule

/* verilog/completion_arbiter.sv */
module completion_arbiter (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             mult_done,
    input  logic [muldiv_pkg::tag_width-1:0] mult_tag,
    input  logic [muldiv_pkg::xlen-1:0]      mult_result,
    input  logic                             div_done,
    input  logic [muldiv_pkg::tag_width-1:0] div_tag,
    input  logic [muldiv_pkg::xlen-1:0]      div_result,
    output logic                             div_grant,
    output logic                             complete_valid,
    output logic [muldiv_pkg::tag_width-1:0] complete_tag,
    output logic [muldiv_pkg::xlen-1:0]      complete_result
);

    // the multiplier cannot stall, so the divider only wins an empty slot
    assign div_grant = div_done && !mult_done;

    always_ff @(posedge clock) begin
        if (reset) begin
            complete_valid <= 1'b0;
        end else begin
            complete_valid <= mult_done || div_done;
        end
    end

    always_ff @(posedge clock) begin
        if (mult_done) begin
            complete_tag    <= mult_tag;
            complete_result <= mult_result;
        end else begin
            // divider result, it stays held when it loses
            complete_tag    <= div_tag;
            complete_result <= div_result;
        end
    end

endmodule

/* verilog/muldiv_unit.sv */
module muldiv_unit (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             issue_valid,
    input  muldiv_pkg::muldiv_func_e         issue_func,
    input  logic [muldiv_pkg::xlen-1:0]      issue_rs1,
    input  logic [muldiv_pkg::xlen-1:0]      issue_rs2,
    input  logic [muldiv_pkg::tag_width-1:0] issue_tag,
    output logic                             div_ready,
    output logic                             complete_valid,
    output logic [muldiv_pkg::tag_width-1:0] complete_tag,
    output logic [muldiv_pkg::xlen-1:0]      complete_result
);
    import muldiv_pkg::*;

    logic                 mult_done;
    logic [tag_width-1:0] mult_tag;
    logic [xlen-1:0]      mult_result;

    logic                 div_done;
    logic                 div_grant;
    logic [tag_width-1:0] div_tag;
    logic [xlen-1:0]      div_result;

    // both units see every issue, each picks its own functions
    mult_pipe mult_pipe_inst (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_func  (issue_func),
        .issue_rs1   (issue_rs1),
        .issue_rs2   (issue_rs2),
        .issue_tag   (issue_tag),
        .mult_done   (mult_done),
        .mult_tag    (mult_tag),
        .mult_result (mult_result)
    );

    div_iter div_iter_inst (
        .clock       (clock),
        .reset       (reset),
        .issue_valid (issue_valid),
        .issue_func  (issue_func),
        .issue_rs1   (issue_rs1),
        .issue_rs2   (issue_rs2),
        .issue_tag   (issue_tag),
        .div_grant   (div_grant),
        .div_ready   (div_ready),
        .div_done    (div_done),
        .div_tag     (div_tag),
        .div_result  (div_result)
    );

    completion_arbiter completion_arbiter_inst (
        .clock           (clock),
        .reset           (reset),
        .mult_done       (mult_done),
        .mult_tag        (mult_tag),
        .mult_result     (mult_result),
        .div_done        (div_done),
        .div_tag         (div_tag),
        .div_result      (div_result),
        .div_grant       (div_grant),
        .complete_valid  (complete_valid),
        .complete_tag    (complete_tag),
        .complete_result (complete_result)
    );

endmodule

/* verif/muldiv_checker.sv */
module muldiv_checker (
    input logic                     clock,
    input logic                     reset,
    input logic                     issue_valid,
    input muldiv_pkg::muldiv_func_e issue_func,
    input logic                     div_ready,
    input logic                     complete_valid,
    input logic                     mult_done,
    input logic                     div_done
);
    import muldiv_pkg::*;

    logic div_issue;

    assign div_issue = issue_valid && (issue_func inside {op_div, op_divu, op_rem, op_remu});

    // a divide may only enter an idle divider
    div_issue_when_ready: assert property (
        @(posedge clock) disable iff (reset) div_issue |-> div_ready
    ) else $error("divide issued while div_ready was low");

    valid_low_after_reset: assert property (
        @(posedge clock) reset |=> !complete_valid
    ) else $error("complete_valid high during or right after reset");

    // a held divide waits out the multiplier
    div_held_while_losing: assert property (
        @(posedge clock) disable iff (reset) (div_done && mult_done) |=> div_done
    ) else $error("divider result dropped while the multiplier owned the output");

endmodule

bind muldiv_unit muldiv_checker muldiv_checker_inst (
    .clock          (clock),
    .reset          (reset),
    .issue_valid    (issue_valid),
    .issue_func     (issue_func),
    .div_ready      (div_ready),
    .complete_valid (complete_valid),
    .mult_done      (mult_done),
    .div_done       (div_done)
);

/* verif/muldiv_model.svh */
`ifndef MULDIV_MODEL_SVH
`define MULDIV_MODEL_SVH

// multiply as the 64-bit signed product of the extended operands
function automatic logic [31:0] product_word(input muldiv_pkg::muldiv_func_e func,
                                             input logic [31:0] a,
                                             input logic [31:0] b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] prod;
    sa = (func == muldiv_pkg::op_mulhu) ? {32'b0, a} : {{32{a[31]}}, a};
    sb = (func == muldiv_pkg::op_mul || func == muldiv_pkg::op_mulh) ?
         {{32{b[31]}}, b} : {32'b0, b};
    prod = sa * sb;
    return (func == muldiv_pkg::op_mul) ? prod[31:0] : prod[63:32];
endfunction

// divide and remainder with the RISC-V corner cases
function automatic logic [31:0] division_result(input muldiv_pkg::muldiv_func_e func,
                                                input logic [31:0] a,
                                                input logic [31:0] b);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic               ovf;
    sa  = a;
    sb  = b;
    ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (func)
        muldiv_pkg::op_div:  return (b == 0) ? 32'hffff_ffff : (ovf ? a : 32'(sa / sb));
        muldiv_pkg::op_divu: return (b == 0) ? 32'hffff_ffff : a / b;
        muldiv_pkg::op_rem:  return (b == 0) ? a : (ovf ? 32'h0 : 32'(sa % sb));
        default:             return (b == 0) ? a : a % b;
    endcase
endfunction

// expected result for any of the eight operations
function automatic logic [31:0] expected_result(input muldiv_pkg::muldiv_func_e func,
                                                input logic [31:0] a,
                                                input logic [31:0] b);
    if (func inside {muldiv_pkg::op_mul, muldiv_pkg::op_mulh,
                     muldiv_pkg::op_mulhsu, muldiv_pkg::op_mulhu}) begin
        return product_word(func, a, b);
    end
    return division_result(func, a, b);
endfunction

`endif

/* verif/muldiv_tb.sv */
module muldiv_tb;
    import muldiv_pkg::*;

    `include "muldiv_model.svh"

    localparam int table_len      = 48;
    localparam int corner_rows    = 20;
    localparam int num_tags       = 1 << tag_width;
    localparam int timeout_cycles = table_len * 40 + 100;

    logic                 clock = 1'b0;
    logic                 reset;
    logic                 issue_valid;
    muldiv_func_e         issue_func;
    logic [xlen-1:0]      issue_rs1;
    logic [xlen-1:0]      issue_rs2;
    logic [tag_width-1:0] issue_tag;
    logic                 div_ready;
    logic                 complete_valid;
    logic [tag_width-1:0] complete_tag;
    logic [xlen-1:0]      complete_result;

    // stimulus rows with their expected results
    muldiv_func_e    tbl_func [table_len];
    logic [xlen-1:0] tbl_rs1  [table_len];
    logic [xlen-1:0] tbl_rs2  [table_len];
    logic [xlen-1:0] tbl_exp  [table_len];

    // scoreboard indexed by tag and written only by the monitor
    logic            pending     [num_tags] = '{default: 1'b0};
    logic [xlen-1:0] exp_result  [num_tags];
    muldiv_func_e    exp_func    [num_tags];
    int              accept_edge [num_tags];

    int   cycle         = 0;
    int   cur_row       = 0;
    int   errors        = 0;      // monitor side
    int   setup_errors  = 0;      // driver side
    int   completions   = 0;
    int   outstanding   = 0;
    logic ready_seen    = 1'b0;   // div_ready as seen at the last falling edge

    muldiv_unit muldiv_unit_inst (
        .clock           (clock),
        .reset           (reset),
        .issue_valid     (issue_valid),
        .issue_func      (issue_func),
        .issue_rs1       (issue_rs1),
        .issue_rs2       (issue_rs2),
        .issue_tag       (issue_tag),
        .div_ready       (div_ready),
        .complete_valid  (complete_valid),
        .complete_tag    (complete_tag),
        .complete_result (complete_result)
    );

    always #2 clock = ~clock;

    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic is_divide(input muldiv_func_e func);
        return func inside {op_div, op_divu, op_rem, op_remu};
    endfunction

    task automatic set_row(input int i, input muldiv_func_e func,
                           input logic [31:0] a, input logic [31:0] b);
        tbl_func[i] = func;
        tbl_rs1[i]  = a;
        tbl_rs2[i]  = b;
    endtask

    task automatic fill_table();
        logic [31:0] r;
        set_row(0,  op_mul,    32'd7,         32'hffff_fffd);
        set_row(1,  op_mulh,   32'h8000_0000, 32'hffff_ffff);   // most negative times -1
        set_row(2,  op_mulhsu, 32'h8000_0000, 32'hffff_ffff);
        set_row(3,  op_mulhu,  32'hffff_ffff, 32'hffff_ffff);
        set_row(4,  op_mul,    32'h8000_0000, 32'hffff_ffff);
        set_row(5,  op_mulh,   32'h7fff_ffff, 32'h7fff_ffff);
        set_row(6,  op_mulhsu, 32'hffff_ffff, 32'h0000_0002);
        set_row(7,  op_mulhu,  32'h1234_5678, 32'h9abc_def0);
        // finishes right after its load cycle into the multiplies still in flight
        set_row(8,  op_div,    32'h0000_1234, 32'h0000_0000);
        set_row(9,  op_mul,    32'hdead_beef, 32'h0000_0010);
        set_row(10, op_mulh,   32'h8000_0000, 32'h8000_0000);
        set_row(11, op_mulhu,  32'h8000_0001, 32'hffff_fffe);
        set_row(12, op_mulhsu, 32'h7fff_ffff, 32'hffff_ffff);
        set_row(13, op_div,    32'h8000_0000, 32'hffff_ffff);   // signed overflow
        set_row(14, op_rem,    32'h8000_0000, 32'hffff_ffff);
        set_row(15, op_divu,   32'h0bad_f00d, 32'h0000_0000);
        set_row(16, op_remu,   32'h0000_0005, 32'h0000_0000);
        set_row(17, op_rem,    32'hffff_fff9, 32'h0000_0000);
        set_row(18, op_div,    32'hffff_fff9, 32'h0000_0002);
        set_row(19, op_rem,    32'hffff_fff9, 32'h0000_0002);
        r = 32'hbc2;
        for (int i = corner_rows; i < table_len; i++) begin
            r = next_random(r);
            tbl_func[i] = muldiv_func_e'(r[30:28]);   // upper bits since the low ones repeat quickly
            r = next_random(r);
            tbl_rs1[i] = r;
            r = next_random(r);
            tbl_rs2[i] = r;
        end
        for (int i = 0; i < table_len; i++) begin
            tbl_exp[i] = expected_result(tbl_func[i], tbl_rs1[i], tbl_rs2[i]);
        end
    endtask

    task automatic check_completion();
        logic [tag_width-1:0] t;
        t = complete_tag;
        completions++;
        if (!pending[t]) begin
            errors++;
            $display("ERR %0t: completion with tag %0d that was not outstanding", $time, t);
        end else begin
            if (complete_result !== exp_result[t]) begin
                errors++;
                $display("ERR %0t: tag %0d %s gave %h, expected %h", $time, t,
                         exp_func[t].name(), complete_result, exp_result[t]);
            end
            // the completion is taken at the next rising edge
            if (!is_divide(exp_func[t]) && (cycle + 1 - accept_edge[t]) != mult_stages + 1) begin
                errors++;
                $display("ERR %0t: tag %0d multiply took %0d cycles, expected %0d", $time, t,
                         cycle + 1 - accept_edge[t], mult_stages + 1);
            end
            pending[t] = 1'b0;
            outstanding--;
        end
    endtask

    task automatic record_issue();
        pending[issue_tag]     = 1'b1;
        exp_result[issue_tag]  = tbl_exp[cur_row];
        exp_func[issue_tag]    = tbl_func[cur_row];
        accept_edge[issue_tag] = cycle + 1;
        outstanding++;
    endtask

    // monitor samples between edges
    always @(negedge clock) begin
        ready_seen = div_ready;
        if (!reset && complete_valid) begin
            check_completion();
        end
        if (!reset && issue_valid) begin
            record_issue();
        end
    end

    always @(posedge clock) begin
        cycle <= cycle + 1;
        if (cycle == timeout_cycles) begin
            $display("timeout after %0d cycles, %0d operations never completed",
                     cycle, outstanding);
            for (int t = 0; t < num_tags; t++) begin
                if (pending[t]) begin
                    $display("tag %0d never completed", t);
                end
            end
            $display("completions: %0d, errors: %0d", completions, errors + setup_errors);
            $display("Done: errors found");
            $finish;
        end
    end

    initial begin
        reset       = 1'b1;
        issue_valid = 1'b0;
        issue_func  = op_mul;
        issue_rs1   = '0;
        issue_rs2   = '0;
        issue_tag   = '0;
        fill_table();

        repeat (2) @(posedge clock);
        reset <= 1'b0;

        @(negedge clock);
        if (complete_valid !== 1'b0 || div_ready !== 1'b1) begin
            setup_errors++;
            $display("ERR %0t: after reset complete_valid=%b div_ready=%b", $time,
                     complete_valid, div_ready);
        end

        for (int i = 0; i < table_len; i++) begin
            @(posedge clock);
            // hold back while the tag is still in flight or the divider is busy
            while (pending[tag_width'(i)] || (is_divide(tbl_func[i]) && !ready_seen)) begin
                issue_valid <= 1'b0;
                @(posedge clock);
            end
            issue_valid <= 1'b1;
            issue_func  <= tbl_func[i];
            issue_rs1   <= tbl_rs1[i];
            issue_rs2   <= tbl_rs2[i];
            issue_tag   <= tag_width'(i);   // wraps modulo 16
            cur_row     <= i;
            if (is_divide(tbl_func[i])) begin
                @(posedge clock);
                issue_valid <= 1'b0;        // one bubble so div_ready shows the accept
            end
        end
        @(posedge clock);
        issue_valid <= 1'b0;

        while (outstanding != 0) begin
            @(negedge clock);
        end
        repeat (10) @(negedge clock);   // room for a stray completion

        if (completions != table_len) begin
            setup_errors++;
            $display("%0d completions seen for %0d issued operations", completions, table_len);
        end
        $display("completions: %0d, errors: %0d", completions, errors + setup_errors);
        if (errors + setup_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+verif
verilog/muldiv_pkg.sv
verilog/mult_stage.sv
verilog/mult_pipe.sv
verilog/div_iter.sv
verilog/completion_arbiter.sv
verilog/muldiv_unit.sv
verif/muldiv_checker.sv
verif/muldiv_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module muldiv_tb -o muldiv_sim

status=0
./obj_dir/muldiv_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -eq 0 ] && grep -qx "Done: no errors" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
